//--- bench/tlbRefModel.svh
// Reference model of the TLB entry table and the expected translation outcome
`ifndef TLB_REF_MODEL_SVH
`define TLB_REF_MODEL_SVH

typedef struct packed {
  tlbPkg::pAdrT pAdr;
  logic         miss;
  logic         fault;
} expRespT;

// Mirror of the table and of the configuration registers
logic             refValid [tlbPkg::tlbEntries];
tlbPkg::vpnT      refVpn [tlbPkg::tlbEntries];
tlbPkg::ppnT      refPpn [tlbPkg::tlbEntries];
tlbPkg::pteBitsT  refPte [tlbPkg::tlbEntries];
int               refPtr = 0;
tlbPkg::vpnT      stagedVpn = '0;
tlbPkg::ppnT      stagedPpn = '0;
tlbPkg::satpModeT satpModel = tlbPkg::satpBare;
logic             mxrModel = 1'b0;
logic             sumModel = 1'b0;
logic             mprvModel = 1'b0;
tlbPkg::privT     mppModel = tlbPkg::uMode;

// Same VPN reuses its slot, a new VPN takes the round-robin slot
function automatic void refillModel(tlbPkg::vpnT vpn, tlbPkg::ppnT ppn, tlbPkg::pteBitsT pte);
  int slot;
  slot = -1;
  for (int i = 0; i < tlbPkg::tlbEntries; i++) begin
    if (refValid[i] && refVpn[i] == vpn) slot = i;
  end
  if (slot < 0) begin
    slot = refPtr;
    refPtr = (refPtr + 1) % tlbPkg::tlbEntries;
  end
  refValid[slot] = 1'b1;
  refVpn[slot] = vpn;
  refPpn[slot] = ppn;
  refPte[slot] = pte;
endfunction

// Pointer survives a flush
function automatic void flushModel();
  for (int i = 0; i < tlbPkg::tlbEntries; i++) refValid[i] = 1'b0;
endfunction

function automatic expRespT expectedResult(tlbPkg::vAdrT vAdr, logic rd, logic wr,
                                           tlbPkg::accSizeT size, tlbPkg::privT priv);
  expRespT         res;
  tlbPkg::privT    mode;
  tlbPkg::pteBitsT pte;
  tlbPkg::ppnT     ppn;
  logic            hit;
  logic            bad;
  mode = mprvModel ? mppModel : priv;
  res.pAdr = vAdr[tlbPkg::pAdrBits-1:0];
  res.miss = 1'b0;
  res.fault = 1'b0;
  // No translation in bare mode or for machine accesses
  if (satpModel != tlbPkg::satpSv39 || mode == tlbPkg::mMode) return res;
  hit = 1'b0;
  pte = '0;
  ppn = '0;
  for (int i = 0; i < tlbPkg::tlbEntries; i++) begin
    if (refValid[i] && refVpn[i] == vAdr[38:12]) begin
      hit = 1'b1;
      pte = refPte[i];
      ppn = refPpn[i];
    end
  end
  res.miss = !hit;
  res.pAdr = {ppn, vAdr[11:0]};
  // Flags are D7 A6 G5 U4 X3 W2 R1 V0
  bad = !pte[0] || !pte[6] || (wr && !pte[7]);
  if (mode == tlbPkg::uMode && !pte[4]) bad = 1'b1;
  if (mode == tlbPkg::sMode && pte[4] && !sumModel) bad = 1'b1;
  if (rd && !pte[1] && !(mxrModel && pte[3])) bad = 1'b1;
  if (wr && !pte[2]) bad = 1'b1;
  if (vAdr[63:39] != {25{vAdr[38]}}) bad = 1'b1;
  if ((vAdr & ((64'd1 << size) - 64'd1)) != 64'd0) bad = 1'b1;
  res.fault = hit && bad;
  return res;
endfunction

`endif

//--- bench/dataTlbTb.sv
// Testbench for the Sv39 data TLB with Wishbone setup, request stream and scoreboard
module dataTlbTb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int clkPeriod   = 40;
  localparam int resetCycles = 16;
  localparam int cyclesPerOp = 40;

  logic            clk;
  logic            arstN;
  logic            wbCyc;
  logic            wbStb;
  logic            wbWe;
  tlbPkg::wbAdrT   wbAdr;
  tlbPkg::wbDataT  wbDatW;
  tlbPkg::wbDataT  wbDatR;
  logic            wbAck;
  logic            reqValid;
  tlbPkg::vAdrT    reqVAdr;
  logic            reqRead;
  logic            reqWrite;
  tlbPkg::accSizeT reqSize;
  tlbPkg::privT    reqPriv;
  logic            reqReady;
  logic            respValid;
  tlbPkg::pAdrT    respPAdr;
  logic            respMiss;
  logic            respPageFault;
  logic            respReady;

  integer seed = 70;
  int     cycleCount = 0;
  int     opCount = 0;

  `include "tlbRefModel.svh"

  expRespT expQ [$];

  dataTlb i_dataTlb (.*);

  initial begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  ////////////////////////////////////////
  // Failure reporting and checks
  ////////////////////////////////////////

  task automatic abortRun(string reason);
    $display("%s", reason);
    $display("Simulation failed");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic checkPAdr(tlbPkg::pAdrT expected, tlbPkg::pAdrT actual);
    if (actual !== expected)
      abortRun($sformatf("MISMATCH at %0t: physical address %h, expected %h",
                         $time, actual, expected));
  endtask

  task automatic checkFlag(string name, logic expected, logic actual);
    if (actual !== expected)
      abortRun($sformatf("MISMATCH at %0t: %s flag %b, expected %b",
                         $time, name, actual, expected));
  endtask

  task automatic checkWbData(tlbPkg::wbAdrT adr, tlbPkg::wbDataT expected,
                             tlbPkg::wbDataT actual);
    if (actual !== expected)
      abortRun($sformatf("MISMATCH at %0t: register 0x%h read %h, expected %h",
                         $time, adr, actual, expected));
  endtask

  // Limit grows with every issued bus or request operation
  always @(posedge clk) begin
    cycleCount = cycleCount + 1;
    if (cycleCount > resetCycles + cyclesPerOp * (opCount + 1))
      abortRun($sformatf("Timeout: no progress after %0d cycles", cycleCount));
  end

  // Drawn at the edge, applied after the drive delay
  initial begin
    logic nextReady;
    respReady = 1'b0;
    forever begin
      @(posedge clk);
      nextReady = ($random(seed) % 4) != 0;
      #2;
      respReady = nextReady;
    end
  end

  // A transfer seen mid-cycle completes on the next rising edge
  always @(negedge clk) begin
    expRespT want;
    if (arstN && respValid && respReady) begin
      if (expQ.size() == 0) begin
        abortRun("Response arrived with no request outstanding");
      end else begin
        want = expQ.pop_front();
        checkFlag("miss", want.miss, respMiss);
        checkFlag("page fault", want.fault, respPageFault);
        if (!want.miss) checkPAdr(want.pAdr, respPAdr);
      end
    end
  end

  ////////////////////////////////////////
  // Drivers
  ////////////////////////////////////////

  function automatic tlbPkg::vAdrT rand64();
    return {$random(seed), $random(seed)};
  endfunction

  function automatic tlbPkg::privT randomPriv();
    tlbPkg::vAdrT bits;
    bits = rand64();
    return (bits[1:0] == 2'd2) ? tlbPkg::sMode : bits[1:0];
  endfunction

  // Canonical address inside the page
  function automatic tlbPkg::vAdrT pageAdr(tlbPkg::vpnT vpn, logic [11:0] offset);
    return {{25{vpn[26]}}, vpn, offset};
  endfunction

  task automatic waitAck(output tlbPkg::wbDataT data);
    logic seen;
    seen = 1'b0;
    while (!seen) begin
      @(negedge clk);
      seen = wbAck;
      data = wbDatR;
      @(posedge clk);
    end
    #2;
    wbCyc = 1'b0;
    wbStb = 1'b0;
    wbWe = 1'b0;
    opCount++;
  endtask

  task automatic wbRead(tlbPkg::wbAdrT adr, output tlbPkg::wbDataT data);
    wbCyc = 1'b1;
    wbStb = 1'b1;
    wbWe = 1'b0;
    wbAdr = adr;
    waitAck(data);
  endtask

  // Bus write plus the matching model update
  task automatic configWrite(tlbPkg::wbAdrT adr, tlbPkg::wbDataT data);
    tlbPkg::wbDataT unused;
    wbCyc = 1'b1;
    wbStb = 1'b1;
    wbWe = 1'b1;
    wbAdr = adr;
    wbDatW = data;
    waitAck(unused);
    case (adr)
      tlbPkg::regSatp: satpModel = data[63:60];
      tlbPkg::regStatus: begin
        mxrModel = data[0];
        sumModel = data[1];
        mprvModel = data[2];
        mppModel = data[4:3];
      end
      tlbPkg::regVpn: stagedVpn = data[26:0];
      tlbPkg::regPpn: stagedPpn = data[43:0];
      tlbPkg::regPte: refillModel(stagedVpn, stagedPpn, data[7:0]);
      tlbPkg::regFlush: flushModel();
      default: ;
    endcase
  endtask

  task automatic refill(tlbPkg::vpnT vpn, tlbPkg::ppnT ppn, tlbPkg::pteBitsT pte);
    configWrite(tlbPkg::regVpn, {37'd0, vpn});
    configWrite(tlbPkg::regPpn, {20'd0, ppn});
    configWrite(tlbPkg::regPte, {56'd0, pte});
  endtask

  task automatic checkReadback(tlbPkg::wbAdrT adr, tlbPkg::wbDataT mask);
    tlbPkg::wbDataT data;
    tlbPkg::wbDataT got;
    data = rand64();
    configWrite(adr, data);
    wbRead(adr, got);
    checkWbData(adr, data & mask, got);
  endtask

  // Expected value is taken when the request is accepted
  task automatic sendRequest(tlbPkg::vAdrT vAdr, logic rd, tlbPkg::accSizeT size,
                             tlbPkg::privT priv);
    logic taken;
    reqValid = 1'b1;
    reqVAdr = vAdr;
    reqRead = rd;
    reqWrite = !rd;
    reqSize = size;
    reqPriv = priv;
    taken = 1'b0;
    while (!taken) begin
      @(negedge clk);
      taken = reqReady;
      @(posedge clk);
    end
    expQ.push_back(expectedResult(vAdr, rd, !rd, size, priv));
    opCount++;
    #2;
  endtask

  // Empty pipe before any reconfiguration
  task automatic drain();
    reqValid = 1'b0;
    while (expQ.size() != 0) @(posedge clk);
    @(posedge clk);
    #2;
  endtask

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin
    tlbPkg::vAdrT r;
    tlbPkg::vAdrT adr;
    tlbPkg::vpnT  pages [9];
    arstN = 1'b0;
    wbCyc = 1'b0;
    wbStb = 1'b0;
    wbWe = 1'b0;
    wbAdr = '0;
    wbDatW = '0;
    reqValid = 1'b0;
    reqVAdr = '0;
    reqRead = 1'b0;
    reqWrite = 1'b0;
    reqSize = '0;
    reqPriv = tlbPkg::uMode;
    flushModel();
    repeat (resetCycles) @(posedge clk);
    #2;
    arstN = 1'b1;

    // Register readback, flush offset reads zero
    checkReadback(tlbPkg::regSatp, 64'hF000_0000_0000_0000);
    checkReadback(tlbPkg::regStatus, 64'h1F);
    checkReadback(tlbPkg::regVpn, 64'h7FF_FFFF);
    checkReadback(tlbPkg::regPpn, 64'hFFF_FFFF_FFFF);
    checkReadback(tlbPkg::regPte, 64'hFF);
    checkReadback(tlbPkg::regFlush, 64'h0);
    configWrite(tlbPkg::regSatp, '0);
    configWrite(tlbPkg::regStatus, '0);

    // Bare mode, then Sv39 with machine accesses
    for (int i = 0; i < 16; i++) begin
      if (i == 8) begin
        drain();
        configWrite(tlbPkg::regSatp, {tlbPkg::satpSv39, 60'd0});
      end
      r = rand64();
      sendRequest(r, r[63], r[62:61], (i < 8) ? randomPriv() : tlbPkg::mMode);
    end
    drain();

    // Hits on refilled pages, misses elsewhere
    for (int i = 0; i < 4; i++) begin
      r = rand64();
      pages[i] = r[26:0];
      refill(pages[i], r[63:20], 8'hD7);
    end
    for (int i = 0; i < 12; i++) begin
      r = rand64();
      adr = pageAdr(r[2] ? pages[r[1:0]] : r[40:14], {r[52:44], 3'b000});
      sendRequest(adr, r[3], 2'd3, tlbPkg::uMode);
    end
    drain();
    configWrite(tlbPkg::regFlush, '0);
    for (int i = 0; i < 4; i++) sendRequest(pageAdr(pages[i], 12'h0), 1'b1, 2'd3, tlbPkg::uMode);
    drain();
    // Ninth refill evicts the first of the nine
    for (int i = 0; i < 9; i++) begin
      r = rand64();
      pages[i] = r[26:0];
      refill(pages[i], r[63:20], 8'hD7);
    end
    for (int i = 0; i < 9; i++) sendRequest(pageAdr(pages[i], 12'h8), 1'b0, 2'd3, tlbPkg::uMode);
    drain();

    // Random flags and status against the fault rule
    for (int i = 0; i < 4; i++) begin
      r = rand64();
      refill(pages[i], r[50:7], r[58:51]);
    end
    for (int round = 0; round < 8; round++) begin
      drain();
      r = rand64();
      if (r[4:3] == 2'd2) r[4:3] = 2'd3;
      configWrite(tlbPkg::regStatus, {59'd0, r[4:0]});
      refill(pages[r[6:5]], r[50:7], r[58:51]);
      for (int k = 0; k < 8; k++) begin
        r = rand64();
        sendRequest(pageAdr(pages[r[1:0]], {r[14:6], 3'b000}), r[2], r[4:3], randomPriv());
      end
    end
    drain();

    // Non-canonical and misaligned addresses on a good page
    configWrite(tlbPkg::regStatus, '0);
    refill(pages[0], 44'h123, 8'hD7);
    for (int k = 0; k < 12; k++) begin
      r = rand64();
      adr = pageAdr(pages[0], r[11:0]);
      if (r[12]) adr[50] = ~adr[50];
      sendRequest(adr, r[13], r[15:14], tlbPkg::uMode);
    end

    // Back-to-back mix under random back-pressure
    for (int k = 0; k < 40; k++) begin
      r = rand64();
      sendRequest(pageAdr(pages[r[1:0]], r[13:2]), r[14], r[16:15], randomPriv());
    end
    drain();

    if (i_dataTlb.i_dataTlbSva.failCount == 0) begin
      $display("Simulation completed successfully");
      $finish;
    end else begin
      abortRun("Assertion checks failed during the run");
    end
  end

endmodule

//--- bench/dataTlb_sva.sv
// Bound checks on the Wishbone ack pulse and the translation response handshake
module dataTlbSva (
  input logic         clk,
  input logic         arstN,
  input logic         wbAck,
  input logic         reqValid,
  input logic         reqReady,
  input logic         respValid,
  input logic         respReady,
  input tlbPkg::pAdrT respPAdr,
  input logic         respMiss,
  input logic         respPageFault
);
  timeunit 1ns;
  timeprecision 100ps;

  int failCount = 0;

  // Ack never stretches past one cycle
  ackOneCycle: assert property (@(posedge clk) disable iff (!arstN) wbAck |=> !wbAck)
    else begin
      $error("wbAck held for more than one cycle");
      failCount++;
    end

  // Stalled response holds every field
  respHeld: assert property (@(posedge clk) disable iff (!arstN)
      respValid && !respReady |=> respValid && $stable(respPAdr) &&
      $stable(respMiss) && $stable(respPageFault))
    else begin
      $error("Response changed while stalled");
      failCount++;
    end

  // Accepted request with two free-running edges after it shows up on the third
  threeStageLatency: assert property (@(posedge clk) disable iff (!arstN)
      reqReady && $past(reqReady) && $past(reqValid && reqReady, 2) |=> respValid)
    else begin
      $error("Response did not appear three edges after an unstalled request");
      failCount++;
    end

endmodule

bind dataTlb dataTlbSva i_dataTlbSva (.*);

//--- dataTlb.f
+incdir+bench
design/tlbPkg.sv
design/tlbConfigPort.sv
design/tlbRequestStage.sv
design/tlbCam.sv
design/tlbControl.sv
design/dataTlb.sv
bench/dataTlb_sva.sv
bench/dataTlbTb.sv

//--- design/dataTlb.sv
// Sv39 data TLB top joining the config port and the three-stage translation pipe
module dataTlb (
  input  logic           clk,
  input  logic           arstN,
  // Wishbone configuration port
  input  logic           wbCyc,
  input  logic           wbStb,
  input  logic           wbWe,
  input  tlbPkg::wbAdrT  wbAdr,
  input  tlbPkg::wbDataT wbDatW,
  output tlbPkg::wbDataT wbDatR,
  output logic           wbAck,
  // Translation request stream
  input  logic           reqValid,
  input  tlbPkg::vAdrT   reqVAdr,
  input  logic           reqRead,
  input  logic           reqWrite,
  input  tlbPkg::accSizeT reqSize,
  input  tlbPkg::privT   reqPriv,
  output logic           reqReady,
  // Translation response stream
  output logic           respValid,
  output tlbPkg::pAdrT   respPAdr,
  output logic           respMiss,
  output logic           respPageFault,
  input  logic           respReady
);

  tlbPkg::satpModeT satpMode;
  logic             statusMxr, statusSum, statusMprv;
  tlbPkg::privT     statusMpp;
  logic             refillValid, flush;
  tlbPkg::vpnT      refillVpn;
  tlbPkg::ppnT      refillPpn;
  tlbPkg::pteBitsT  refillPte;
  logic             stall, stageEnable;
  logic             s1Valid, s1Read, s1Write, s1Translate, s1NonCanonical, s1Misaligned;
  tlbPkg::vAdrT     s1VAdr, s2VAdr;
  tlbPkg::privT     s1Priv, s2Priv;
  logic             s2Valid, s2Read, s2Write, s2Translate, s2NonCanonical, s2Misaligned;
  logic             s2Hit;
  tlbPkg::ppnT      s2Ppn;
  tlbPkg::pteBitsT  s2Pte;

  // Whole pipe freezes while a response waits
  assign stall       = respValid & ~respReady;
  assign stageEnable = ~stall;
  assign reqReady    = stageEnable;

  tlbConfigPort i_tlbConfigPort (
    .clk, .arstN, .wbCyc, .wbStb, .wbWe, .wbAdr, .wbDatW, .wbDatR, .wbAck,
    .satpMode, .statusMxr, .statusSum, .statusMprv, .statusMpp,
    .refillValid, .refillVpn, .refillPpn, .refillPte, .flush
  );

  tlbRequestStage i_tlbRequestStage (
    .clk, .arstN, .stageEnable, .reqValid, .reqVAdr, .reqRead, .reqWrite,
    .reqSize, .reqPriv, .satpMode, .statusMprv, .statusMpp,
    .s1Valid, .s1VAdr, .s1Read, .s1Write, .s1Priv, .s1Translate,
    .s1NonCanonical, .s1Misaligned
  );

  tlbCam i_tlbCam (
    .clk, .arstN, .stageEnable, .s1Valid, .s1VAdr, .s1Read, .s1Write, .s1Priv,
    .s1Translate, .s1NonCanonical, .s1Misaligned,
    .refillValid, .refillVpn, .refillPpn, .refillPte, .flush,
    .s2Valid, .s2VAdr, .s2Read, .s2Write, .s2Priv, .s2Translate,
    .s2NonCanonical, .s2Misaligned, .s2Hit, .s2Ppn, .s2Pte
  );

  tlbControl i_tlbControl (
    .clk, .arstN, .stageEnable, .s2Valid, .s2VAdr, .s2Read, .s2Write, .s2Priv,
    .s2Translate, .s2NonCanonical, .s2Misaligned, .s2Hit, .s2Ppn, .s2Pte,
    .statusMxr, .statusSum, .respValid, .respPAdr, .respMiss, .respPageFault
  );

endmodule

//--- design/tlbCam.sv
// Second TLB stage with eight fully associative entries and round-robin refill
module tlbCam (
  input  logic            clk,
  input  logic            arstN,
  input  logic            stageEnable,
  input  logic            s1Valid,
  input  tlbPkg::vAdrT    s1VAdr,
  input  logic            s1Read,
  input  logic            s1Write,
  input  tlbPkg::privT    s1Priv,
  input  logic            s1Translate,
  input  logic            s1NonCanonical,
  input  logic            s1Misaligned,
  input  logic            refillValid,
  input  tlbPkg::vpnT     refillVpn,
  input  tlbPkg::ppnT     refillPpn,
  input  tlbPkg::pteBitsT refillPte,
  input  logic            flush,
  output logic            s2Valid,
  output tlbPkg::vAdrT    s2VAdr,
  output logic            s2Read,
  output logic            s2Write,
  output tlbPkg::privT    s2Priv,
  output logic            s2Translate,
  output logic            s2NonCanonical,
  output logic            s2Misaligned,
  output logic            s2Hit,
  output tlbPkg::ppnT     s2Ppn,
  output tlbPkg::pteBitsT s2Pte
);

  logic [tlbPkg::tlbEntries-1:0]   entryValid;
  tlbPkg::vpnT                     entryVpn [tlbPkg::tlbEntries];
  tlbPkg::ppnT                     entryPpn [tlbPkg::tlbEntries];
  tlbPkg::pteBitsT                 entryPte [tlbPkg::tlbEntries];
  logic [tlbPkg::tlbIndexBits-1:0] rrPtr;
  logic [tlbPkg::tlbIndexBits-1:0] refillMatchIdx;
  logic [tlbPkg::tlbIndexBits-1:0] victimIdx;
  logic                            refillMatch;
  tlbPkg::vpnT                     lookupVpn;
  logic                            lookupHit;
  tlbPkg::ppnT                     lookupPpn;
  tlbPkg::pteBitsT                 lookupPte;

  ////////////////////////////////////////
  // Refill and flush
  ////////////////////////////////////////

  // Existing copy of the page is overwritten so VPNs stay unique
  always_comb begin
    refillMatch    = 1'b0;
    refillMatchIdx = '0;
    for (int i = 0; i < tlbPkg::tlbEntries; i++) begin
      if (entryValid[i] && (entryVpn[i] == refillVpn)) begin
        refillMatch    = 1'b1;
        refillMatchIdx = i[tlbPkg::tlbIndexBits-1:0];
      end
    end
  end

  assign victimIdx = refillMatch ? refillMatchIdx : rrPtr;

  // Flush leaves the replacement pointer where it is
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      entryValid <= '0;
      rrPtr      <= '0;
    end else if (flush) begin
      entryValid <= '0;
    end else if (refillValid) begin
      entryValid[victimIdx] <= 1'b1;
      if (!refillMatch) rrPtr <= rrPtr + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (refillValid) begin
      entryVpn[victimIdx] <= refillVpn;
      entryPpn[victimIdx] <= refillPpn;
      entryPte[victimIdx] <= refillPte;
    end
  end

  ////////////////////////////////////////
  // Lookup
  ////////////////////////////////////////

  assign lookupVpn = s1VAdr[tlbPkg::pageOffsetBits+tlbPkg::vpnBits-1:tlbPkg::pageOffsetBits];

  // At most one entry can match
  always_comb begin
    lookupHit = 1'b0;
    lookupPpn = '0;
    lookupPte = '0;
    for (int i = 0; i < tlbPkg::tlbEntries; i++) begin
      if (entryValid[i] && (entryVpn[i] == lookupVpn)) begin
        lookupHit = 1'b1;
        lookupPpn = entryPpn[i];
        lookupPte = entryPte[i];
      end
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) s2Valid <= 1'b0;
    else if (stageEnable) s2Valid <= s1Valid;
  end

  always_ff @(posedge clk) begin
    if (stageEnable) begin
      s2VAdr         <= s1VAdr;
      s2Read         <= s1Read;
      s2Write        <= s1Write;
      s2Priv         <= s1Priv;
      s2Translate    <= s1Translate;
      s2NonCanonical <= s1NonCanonical;
      s2Misaligned   <= s1Misaligned;
      s2Hit          <= lookupHit;
      s2Ppn          <= lookupPpn;
      s2Pte          <= lookupPte;
    end
  end

endmodule

//--- design/tlbConfigPort.sv
// Wishbone classic slave with SATP mode, status bits, refill staging and flush
module tlbConfigPort (
  input  logic             clk,
  input  logic             arstN,
  input  logic             wbCyc,
  input  logic             wbStb,
  input  logic             wbWe,
  input  tlbPkg::wbAdrT    wbAdr,
  input  tlbPkg::wbDataT   wbDatW,
  output tlbPkg::wbDataT   wbDatR,
  output logic             wbAck,
  output tlbPkg::satpModeT satpMode,
  output logic             statusMxr,
  output logic             statusSum,
  output logic             statusMprv,
  output tlbPkg::privT     statusMpp,
  output logic             refillValid,
  output tlbPkg::vpnT      refillVpn,
  output tlbPkg::ppnT      refillPpn,
  output tlbPkg::pteBitsT  refillPte,
  output logic             flush
);

  tlbPkg::wbStateT wbState;
  tlbPkg::pteBitsT pteReg;
  logic            writeStrobe;

  // One idle cycle then exactly one ack cycle per transfer
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      wbState <= tlbPkg::wbIdle;
    end else if (wbState == tlbPkg::wbIdle) begin
      if (wbCyc && wbStb) wbState <= tlbPkg::wbAck;
    end else begin
      wbState <= tlbPkg::wbIdle;
    end
  end

  assign wbAck       = (wbState == tlbPkg::wbAck);
  // Master holds address and data stable through the ack cycle
  assign writeStrobe = wbAck && wbWe;

  ////////////////////////////////////////
  // Register writes
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      satpMode   <= tlbPkg::satpBare;
      statusMxr  <= 1'b0;
      statusSum  <= 1'b0;
      statusMprv <= 1'b0;
      statusMpp  <= tlbPkg::uMode;
      refillVpn  <= '0;
      refillPpn  <= '0;
      pteReg     <= '0;
    end else if (writeStrobe) begin
      case (wbAdr)
        tlbPkg::regSatp: satpMode <= wbDatW[63:60];
        tlbPkg::regStatus: begin
          statusMxr  <= wbDatW[0];
          statusSum  <= wbDatW[1];
          statusMprv <= wbDatW[2];
          statusMpp  <= wbDatW[4:3];
        end
        tlbPkg::regVpn: refillVpn <= wbDatW[tlbPkg::vpnBits-1:0];
        tlbPkg::regPpn: refillPpn <= wbDatW[tlbPkg::ppnBits-1:0];
        tlbPkg::regPte: pteReg    <= wbDatW[7:0];
        default: ;
      endcase
    end
  end

  // Strobes fire during the ack of the matching write
  assign refillValid = writeStrobe && (wbAdr == tlbPkg::regPte);
  assign flush       = writeStrobe && (wbAdr == tlbPkg::regFlush);
  // Flag byte comes straight from the committing write
  assign refillPte   = wbDatW[7:0];

  ////////////////////////////////////////
  // Readback
  ////////////////////////////////////////

  always_comb begin
    wbDatR = '0;
    case (wbAdr)
      tlbPkg::regSatp:   wbDatR[63:60] = satpMode;
      tlbPkg::regStatus: wbDatR[4:0]   = {statusMpp, statusMprv, statusSum, statusMxr};
      tlbPkg::regVpn:    wbDatR[tlbPkg::vpnBits-1:0] = refillVpn;
      tlbPkg::regPpn:    wbDatR[tlbPkg::ppnBits-1:0] = refillPpn;
      tlbPkg::regPte:    wbDatR[7:0]   = pteReg;
      default:           wbDatR        = '0;  // Flush and unmapped offsets
    endcase
  end

endmodule

//--- design/tlbControl.sv
// Third TLB stage checking page permissions and forming the physical address
module tlbControl (
  input  logic            clk,
  input  logic            arstN,
  input  logic            stageEnable,
  input  logic            s2Valid,
  input  tlbPkg::vAdrT    s2VAdr,
  input  logic            s2Read,
  input  logic            s2Write,
  input  tlbPkg::privT    s2Priv,
  input  logic            s2Translate,
  input  logic            s2NonCanonical,
  input  logic            s2Misaligned,
  input  logic            s2Hit,
  input  tlbPkg::ppnT     s2Ppn,
  input  tlbPkg::pteBitsT s2Pte,
  input  logic            statusMxr,
  input  logic            statusSum,
  output logic            respValid,
  output tlbPkg::pAdrT    respPAdr,
  output logic            respMiss,
  output logic            respPageFault
);

  logic         pteD, pteA, pteU, pteX, pteW, pteR, pteV;
  logic         improperPrivilege;
  logic         invalidRead;
  logic         invalidWrite;
  logic         daFault;
  logic         miss;
  logic         pageFault;
  tlbPkg::pAdrT pAdr;

  // Split the flag byte, G is not used without ASIDs
  assign {pteD, pteA} = s2Pte[7:6];
  assign {pteU, pteX, pteW, pteR, pteV} = s2Pte[4:0];

  ////////////////////////////////////////
  // Permission rules
  ////////////////////////////////////////

  // User only on U pages, supervisor on U pages only with SUM
  assign improperPrivilege = ((s2Priv == tlbPkg::uMode) & ~pteU) |
                             ((s2Priv == tlbPkg::sMode) & pteU & ~statusSum);

  // MXR makes executable pages readable
  assign invalidRead  = s2Read & ~pteR & (~statusMxr | ~pteX);
  assign invalidWrite = s2Write & ~pteW;

  // Software manages A and D so either case traps
  assign daFault = ~pteA | (s2Write & ~pteD);

  assign miss      = s2Translate & ~s2Hit;
  assign pageFault = s2Translate & s2Hit &
                     (improperPrivilege | invalidRead | invalidWrite | daFault |
                      s2NonCanonical | s2Misaligned | ~pteV);

  // Untranslated accesses keep the low physical bits of the virtual address
  assign pAdr = s2Translate ? {s2Ppn, s2VAdr[tlbPkg::pageOffsetBits-1:0]}
                            : s2VAdr[tlbPkg::pAdrBits-1:0];

  ////////////////////////////////////////
  // Response register
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      respValid     <= 1'b0;
      respMiss      <= 1'b0;
      respPageFault <= 1'b0;
    end else if (stageEnable) begin
      respValid     <= s2Valid;
      respMiss      <= miss;
      respPageFault <= pageFault;
    end
  end

  always_ff @(posedge clk) begin
    if (stageEnable) respPAdr <= pAdr;
  end

endmodule

//--- design/tlbPkg.sv
// Sv39 data TLB shared widths, vector types, mode constants and register map
package tlbPkg;

  ////////////////////////////////////////
  // Widths
  ////////////////////////////////////////

  localparam int xLen           = 64;
  localparam int vpnBits        = 27;  // Three 9-bit VPN fields of Sv39
  localparam int ppnBits        = 44;
  localparam int pAdrBits       = 56;
  localparam int pageOffsetBits = 12;  // 4 KiB pages only
  localparam int tlbEntries     = 8;
  localparam int tlbIndexBits   = 3;

  ////////////////////////////////////////
  // Vector types
  ////////////////////////////////////////

  typedef logic [xLen-1:0]     vAdrT;
  typedef logic [pAdrBits-1:0] pAdrT;
  typedef logic [vpnBits-1:0]  vpnT;
  typedef logic [ppnBits-1:0]  ppnT;
  // PTE flags from bit 7 down are D A G U X W R V
  typedef logic [7:0]          pteBitsT;
  typedef logic [1:0]          privT;
  typedef logic [3:0]          satpModeT;
  // Access size as log2 of the byte count
  typedef logic [1:0]          accSizeT;
  typedef logic [5:0]          wbAdrT;
  typedef logic [63:0]         wbDataT;

  // Privilege modes
  localparam privT uMode = 2'd0;
  localparam privT sMode = 2'd1;
  localparam privT mMode = 2'd3;

  // SATP mode field values
  localparam satpModeT satpBare = 4'd0;
  localparam satpModeT satpSv39 = 4'd8;

  ////////////////////////////////////////
  // Configuration register byte offsets
  ////////////////////////////////////////

  localparam wbAdrT regSatp   = 6'h00;  // Mode in bits 63:60 as in the satp CSR
  localparam wbAdrT regStatus = 6'h08;  // MXR 0, SUM 1, MPRV 2, MPP 4:3
  localparam wbAdrT regVpn    = 6'h10;
  localparam wbAdrT regPpn    = 6'h18;
  localparam wbAdrT regPte    = 6'h20;  // Write commits the staged refill
  localparam wbAdrT regFlush  = 6'h28;  // Write invalidates every entry

  // Wishbone slave handshake states
  typedef enum logic {wbIdle, wbAck} wbStateT;

endpackage

//--- design/tlbRequestStage.sv
// First TLB stage qualifying a load or store request before lookup
module tlbRequestStage (
  input  logic             clk,
  input  logic             arstN,
  input  logic             stageEnable,
  input  logic             reqValid,
  input  tlbPkg::vAdrT     reqVAdr,
  input  logic             reqRead,
  input  logic             reqWrite,
  input  tlbPkg::accSizeT  reqSize,
  input  tlbPkg::privT     reqPriv,
  input  tlbPkg::satpModeT satpMode,
  input  logic             statusMprv,
  input  tlbPkg::privT     statusMpp,
  output logic             s1Valid,
  output tlbPkg::vAdrT     s1VAdr,
  output logic             s1Read,
  output logic             s1Write,
  output tlbPkg::privT     s1Priv,
  output logic             s1Translate,
  output logic             s1NonCanonical,
  output logic             s1Misaligned
);

  tlbPkg::privT effPriv;
  logic         translate;
  logic         nonCanonical;
  logic         misaligned;

  // Data accesses run at MPP while MPRV is set
  assign effPriv   = statusMprv ? statusMpp : reqPriv;
  assign translate = (satpMode == tlbPkg::satpSv39) && (effPriv != tlbPkg::mMode);

  // Sv39 upper bits must copy bit 38
  assign nonCanonical = (reqVAdr[63:39] != {25{reqVAdr[38]}});

  // Low address bits must be clear for the access size
  always_comb begin
    case (reqSize)
      2'd0:    misaligned = 1'b0;
      2'd1:    misaligned = reqVAdr[0];
      2'd2:    misaligned = |reqVAdr[1:0];
      default: misaligned = |reqVAdr[2:0];
    endcase
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) s1Valid <= 1'b0;
    else if (stageEnable) s1Valid <= reqValid;
  end

  // Request payload
  always_ff @(posedge clk) begin
    if (stageEnable) begin
      s1VAdr         <= reqVAdr;
      s1Read         <= reqRead;
      s1Write        <= reqWrite;
      s1Priv         <= effPriv;  // Later stages see the effective mode
      s1Translate    <= translate;
      s1NonCanonical <= nonCanonical;
      s1Misaligned   <= misaligned;
    end
  end

endmodule

//--- runSim.sh
#!/usr/bin/env bash
# Build the data TLB testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
logFile=sim.log

if ! verilator --binary --timing --assert \
    -f dataTlb.f \
    --top-module dataTlbTb \
    -Mdir "$buildDir"; then
  echo "Build failed"
  exit 1
fi

if ! "./$buildDir/VdataTlbTb" > "$logFile" 2>&1; then
  cat "$logFile"
  echo "Simulation run returned an error status"
  exit 1
fi

cat "$logFile"

if grep -q "Simulation completed successfully" "$logFile"; then
  exit 0
fi
echo "Pass message not found in $logFile"
exit 1
